// ==== hw/per_pkg.sv ====
`default_nettype none

package per_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------
	localparam int DATA_W          = 32;   // bus data and register words
	localparam int ADDR_W          = 30;   // byte addressable
	localparam int SEED_W          = 19;   // rate shift seed
	localparam int SEL_W           = 2;    // cpc metric switch
	localparam int N_COUNTERS      = 6;    // core cycle counters, 192b together
	localparam int CNT_IDX_W       = $clog2(N_COUNTERS);
	localparam int RST_HOLD_CYCLES = 16;   // system reset pulse length
	localparam int RST_CNT_W       = $clog2(RST_HOLD_CYCLES);

	// ----------------------------------------
	// register map, byte offsets
	// ----------------------------------------
	localparam logic [ADDR_W-1:0] REG_COMM       = 'h00;
	localparam logic [ADDR_W-1:0] REG_METRIC     = 'h04;
	localparam logic [ADDR_W-1:0] REG_SEED       = 'h08;
	localparam logic [ADDR_W-1:0] REG_PHASE      = 'h0C;
	localparam logic [ADDR_W-1:0] REG_RESET      = 'h10; // bit 0 starts pulse, reads busy
	localparam logic [ADDR_W-1:0] REG_CACHE0     = 'h14; // read only
	localparam logic [ADDR_W-1:0] REG_CACHE1     = 'h18; // read only
	localparam logic [ADDR_W-1:0] REG_SNAP       = 'h1C; // any write captures status
	localparam logic [ADDR_W-1:0] REG_COUNT_BASE = 'h20; // counters 0..5, read only
	localparam logic [ADDR_W-1:0] REG_COUNT_LAST = REG_COUNT_BASE + ADDR_W'(4 * (N_COUNTERS - 1));

	// reset values of the control words
	localparam logic [DATA_W-1:0] COMM_RESET  = 32'h0;
	localparam logic [DATA_W-1:0] PHASE_RESET = 32'h0000_0001;

	// writable register lanes, bit positions of wr_cmd_t.sel
	localparam int N_WR_REGS = 4;
	localparam int WR_COMM   = 0;
	localparam int WR_METRIC = 1;
	localparam int WR_SEED   = 2;
	localparam int WR_PHASE  = 3;

	// ----------------------------------------
	// structs
	// ----------------------------------------
	typedef struct packed {
		logic              req;  // single cycle strobe
		logic              rw;   // 1 = write
		logic [ADDR_W-1:0] add;
		logic [DATA_W-1:0] data;
	} bus_req_t;

	// control words as the core and caches see them
	typedef struct packed {
		logic [DATA_W-1:0] comm;
		logic [DATA_W-1:0] phase;
		logic [SEL_W-1:0]  metric_sel;
		logic [SEED_W-1:0] seed;
	} ctrl_word_t;

	typedef struct packed {
		logic [N_COUNTERS-1:0][DATA_W-1:0] word; // word[0] is counter 0
	} count_bank_t;

	// merged write, one select bit and one data lane per writable register
	typedef struct packed {
		logic [N_WR_REGS-1:0]             sel;
		logic [N_WR_REGS-1:0][DATA_W-1:0] data;
	} wr_cmd_t;

endpackage

`default_nettype wire

// ==== hw/per_snapshot.sv ====
`timescale 1ns/100ps
`default_nettype none

// frozen copy of a live status source
module per_snapshot #(
	parameter type payload_t = logic [per_pkg::DATA_W-1:0]
) (
	input  wire            clock_i,
	input  wire            rst_n_i,
	input  wire            capture_i, // from a REG_SNAP write
	input  wire  payload_t data_i,    // live value
	output payload_t       snap_o
);

	// all instances share capture_i, so
	// counters and cache words come from the same cycle
	always_ff @(posedge clock_i) begin
		if (!rst_n_i)
			snap_o <= '0;
		else if (capture_i)
			snap_o <= data_i; // hold until next capture
	end

endmodule

`default_nettype wire

// ==== hw/per_reset_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module per_reset_gen (
	input  wire   clock_i,
	input  wire   rst_n_i,
	input  wire   start_i,        // single cycle command
	output logic  reset_system_o, // restarts the core
	output logic  busy_o
);

	logic [per_pkg::RST_CNT_W-1:0] hold_cnt; // cycles left after the current one

	// ----------------------------------------
	// pulse stretcher
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			reset_system_o <= 1'b1;   // core held while we are in reset
			hold_cnt       <= '0;     // drops on first edge after release
		end else if (!reset_system_o) begin
			if (start_i) begin
				reset_system_o <= 1'b1;
				hold_cnt       <= per_pkg::RST_CNT_W'(per_pkg::RST_HOLD_CYCLES - 1);
			end
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1; // starts ignored here
		end else begin
			reset_system_o <= 1'b0;      // end of pulse
		end
	end

	assign busy_o = reset_system_o;

endmodule

`default_nettype wire

// ==== hw/per_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module per_regs (
	input  wire                       clock_i,
	input  wire                       rst_n_i,
	input  wire  per_pkg::wr_cmd_t    wr_i,    // merged writes from per_ctrl
	output per_pkg::ctrl_word_t       ctrl_o
);

	// ----------------------------------------
	// control words
	// ----------------------------------------
	logic [per_pkg::DATA_W-1:0] comm_q;   // core comm word
	logic [per_pkg::DATA_W-1:0] phase_q;  // clock phase word
	logic [per_pkg::SEL_W-1:0]  metric_q; // cpc metric switch
	logic [per_pkg::SEED_W-1:0] seed_q;   // rate shift seed

	// comm word
	always_ff @(posedge clock_i) begin
		if (!rst_n_i)
			comm_q <= per_pkg::COMM_RESET;
		else if (wr_i.sel[per_pkg::WR_COMM])
			comm_q <= wr_i.data[per_pkg::WR_COMM];
	end

	// phase word, comes up as 1
	always_ff @(posedge clock_i) begin
		if (!rst_n_i)
			phase_q <= per_pkg::PHASE_RESET;
		else if (wr_i.sel[per_pkg::WR_PHASE])
			phase_q <= wr_i.data[per_pkg::WR_PHASE];
	end

	// metric select, low bits only
	always_ff @(posedge clock_i) begin
		if (!rst_n_i)
			metric_q <= '0;
		else if (wr_i.sel[per_pkg::WR_METRIC])
			metric_q <= wr_i.data[per_pkg::WR_METRIC][per_pkg::SEL_W-1:0];
	end

	// seed, upper bits dropped
	always_ff @(posedge clock_i) begin
		if (!rst_n_i)
			seed_q <= '0;
		else if (wr_i.sel[per_pkg::WR_SEED])
			seed_q <= wr_i.data[per_pkg::WR_SEED][per_pkg::SEED_W-1:0];
	end

	// ----------------------------------------
	// out to core / cache
	// ----------------------------------------
	always_comb begin
		ctrl_o.comm       = comm_q;
		ctrl_o.phase      = phase_q;
		ctrl_o.metric_sel = metric_q;
		ctrl_o.seed       = seed_q;
	end

endmodule

`default_nettype wire

// ==== hw/per_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module per_ctrl (
	input  wire                                clock_i,
	input  wire                                rst_n_i,
	input  wire  per_pkg::bus_req_t            core_req_i,    // core side strobes
	input  wire  per_pkg::bus_req_t            ext_req_i,     // comm side strobes
	input  wire  per_pkg::ctrl_word_t          regs_i,
	input  wire  [per_pkg::DATA_W-1:0]         cache0_snap_i,
	input  wire  [per_pkg::DATA_W-1:0]         cache1_snap_i,
	input  wire  per_pkg::count_bank_t         counts_snap_i,
	input  wire                                reset_busy_i,
	output per_pkg::wr_cmd_t                   wr_o,
	output logic                               snap_o,        // capture all snapshots
	output logic                               reset_start_o,
	output logic [per_pkg::DATA_W-1:0]         core_rdata_o,
	output logic [per_pkg::DATA_W-1:0]         ext_rdata_o
);

	logic [per_pkg::N_WR_REGS-1:0] core_sel, ext_sel;
	logic                          core_rst_hit, ext_rst_hit;

	// ----------------------------------------
	// decode
	// ----------------------------------------

	// true for a write strobe to one exact register
	function automatic logic wr_hit(input per_pkg::bus_req_t r, input logic [per_pkg::ADDR_W-1:0] reg_add);
		return r.req && r.rw && (r.add == reg_add);
	endfunction

	// one-hot lane of a writable control register, zero otherwise
	function automatic logic [per_pkg::N_WR_REGS-1:0] write_sel(input per_pkg::bus_req_t r);
		logic [per_pkg::N_WR_REGS-1:0] sel;
		sel = '0;
		if (r.req && r.rw) begin
			case (r.add) // misaligned never matches
				per_pkg::REG_COMM:   sel[per_pkg::WR_COMM]   = 1'b1;
				per_pkg::REG_METRIC: sel[per_pkg::WR_METRIC] = 1'b1;
				per_pkg::REG_SEED:   sel[per_pkg::WR_SEED]   = 1'b1;
				per_pkg::REG_PHASE:  sel[per_pkg::WR_PHASE]  = 1'b1;
				default:             sel = '0; // read only or unmapped
			endcase
		end
		return sel;
	endfunction

	// read mux, shared by both ports
	function automatic logic [per_pkg::DATA_W-1:0] read_word(input logic [per_pkg::ADDR_W-1:0] add);
		logic [per_pkg::ADDR_W-1:0] cnt_off;
		logic [per_pkg::DATA_W-1:0] word;
		cnt_off = add - per_pkg::REG_COUNT_BASE;
		word    = '0;
		case (add)
			per_pkg::REG_COMM:   word = regs_i.comm;
			per_pkg::REG_METRIC: word[per_pkg::SEL_W-1:0]  = regs_i.metric_sel;
			per_pkg::REG_SEED:   word[per_pkg::SEED_W-1:0] = regs_i.seed;
			per_pkg::REG_PHASE:  word = regs_i.phase;
			per_pkg::REG_RESET:  word[0] = reset_busy_i;
			per_pkg::REG_CACHE0: word = cache0_snap_i;
			per_pkg::REG_CACHE1: word = cache1_snap_i;
			default: begin
				// counter window, word aligned only
				if (add >= per_pkg::REG_COUNT_BASE && add <= per_pkg::REG_COUNT_LAST
						&& add[1:0] == 2'b00)
					word = counts_snap_i.word[cnt_off[per_pkg::CNT_IDX_W+1:2]];
			end
		endcase
		return word;
	endfunction

	// ----------------------------------------
	// write steering
	// ----------------------------------------
	assign core_sel     = write_sel(core_req_i);
	assign ext_sel      = write_sel(ext_req_i);
	assign core_rst_hit = wr_hit(core_req_i, per_pkg::REG_RESET);
	assign ext_rst_hit  = wr_hit(ext_req_i, per_pkg::REG_RESET);

	always_comb begin
		wr_o.sel = core_sel | ext_sel; // both land when registers differ
		for (int i = 0; i < per_pkg::N_WR_REGS; i++) begin
			// core wins a collision on the same lane
			wr_o.data[i] = core_sel[i] ? core_req_i.data : ext_req_i.data;
		end
	end

	// capture strobe, same edge as the write
	assign snap_o = wr_hit(core_req_i, per_pkg::REG_SNAP) | wr_hit(ext_req_i, per_pkg::REG_SNAP);

	// reset command, core data has priority
	assign reset_start_o = core_rst_hit ? core_req_i.data[0] : (ext_rst_hit & ext_req_i.data[0]);

	// ----------------------------------------
	// registered read data, one per port
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			core_rdata_o <= '0;
			ext_rdata_o  <= '0;
		end else begin
			if (core_req_i.req && !core_req_i.rw)
				core_rdata_o <= read_word(core_req_i.add); // held till next core read
			if (ext_req_i.req && !ext_req_i.rw)
				ext_rdata_o <= read_word(ext_req_i.add);
		end
	end

endmodule

`default_nettype wire

// ==== hw/peripheral_system.sv ====
`timescale 1ns/100ps
`default_nettype none

module peripheral_system (
	// system
	input  wire                          clock_i,
	input  wire                          rst_n_i,

	// requesters
	input  wire  per_pkg::bus_req_t      core_req_i,  // internal system
	input  wire  per_pkg::bus_req_t      ext_req_i,   // comm side

	// status from the caches and core
	input  wire  [per_pkg::DATA_W-1:0]   cache0_i,
	input  wire  [per_pkg::DATA_W-1:0]   cache1_i,
	input  wire  per_pkg::count_bank_t   counts_i,

	// read data
	output logic [per_pkg::DATA_W-1:0]   core_rdata_o,
	output logic [per_pkg::DATA_W-1:0]   ext_rdata_o,

	// control out
	output per_pkg::ctrl_word_t          ctrl_o,      // comm, phase, metric, seed
	output logic                         reset_system_o
);

	per_pkg::wr_cmd_t           wr_cmd;
	logic                       snap_pulse;
	logic                       reset_start;
	logic                       reset_busy;
	logic [per_pkg::DATA_W-1:0] cache0_snap, cache1_snap;
	per_pkg::count_bank_t       counts_snap;

	// ----------------------------------------
	// decode and read mux
	// ----------------------------------------
	per_ctrl ctrl_inst (
		.clock_i       (clock_i      ),
		.rst_n_i       (rst_n_i      ),
		.core_req_i    (core_req_i   ),
		.ext_req_i     (ext_req_i    ),
		.regs_i        (ctrl_o       ), // read back of control words
		.cache0_snap_i (cache0_snap  ),
		.cache1_snap_i (cache1_snap  ),
		.counts_snap_i (counts_snap  ),
		.reset_busy_i  (reset_busy   ),
		.wr_o          (wr_cmd       ),
		.snap_o        (snap_pulse   ),
		.reset_start_o (reset_start  ),
		.core_rdata_o  (core_rdata_o ),
		.ext_rdata_o   (ext_rdata_o  )
	);

	per_regs regs_inst (
		.clock_i (clock_i ),
		.rst_n_i (rst_n_i ),
		.wr_i    (wr_cmd  ),
		.ctrl_o  (ctrl_o  )
	);

	// ----------------------------------------
	// status snapshots
	// ----------------------------------------
	per_snapshot #(.payload_t(logic [per_pkg::DATA_W-1:0])) snap_cache0_inst (
		.clock_i   (clock_i     ),
		.rst_n_i   (rst_n_i     ),
		.capture_i (snap_pulse  ),
		.data_i    (cache0_i    ),
		.snap_o    (cache0_snap )
	);

	per_snapshot #(.payload_t(logic [per_pkg::DATA_W-1:0])) snap_cache1_inst (
		.clock_i   (clock_i     ),
		.rst_n_i   (rst_n_i     ),
		.capture_i (snap_pulse  ),
		.data_i    (cache1_i    ),
		.snap_o    (cache1_snap )
	);

	per_snapshot #(.payload_t(per_pkg::count_bank_t)) snap_counts_inst (
		.clock_i   (clock_i     ),
		.rst_n_i   (rst_n_i     ),
		.capture_i (snap_pulse  ),
		.data_i    (counts_i    ), // 192b bank
		.snap_o    (counts_snap )
	);

	// system reset pulse
	per_reset_gen reset_gen_inst (
		.clock_i        (clock_i        ),
		.rst_n_i        (rst_n_i        ),
		.start_i        (reset_start    ),
		.reset_system_o (reset_system_o ),
		.busy_o         (reset_busy     )
	);

endmodule

`default_nettype wire

// ==== verification/tb_peripheral_system.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_peripheral_system;

	// ----------------------------------------
	// constants and dut wiring
	// ----------------------------------------
	localparam int         STIM_DEPTH = 64;
	localparam int         WAIT_LIMIT = 200;  // cycles per wait loop
	localparam logic [3:0] OP_WRITE   = 4'h1;
	localparam logic [3:0] OP_READ    = 4'h2;
	localparam logic [3:0] OP_BOTH    = 4'h3; // addr = {ext, core}, expect = ext data
	localparam logic [3:0] OP_SNAP    = 4'h4;
	localparam logic [3:0] OP_RESET   = 4'h5; // expect = pulse length
	localparam logic [3:0] OP_END     = 4'hF;

	logic                       clock = 1'b0;
	logic                       rst_n;
	per_pkg::bus_req_t          core_req, ext_req;
	logic [per_pkg::DATA_W-1:0] cache0, cache1;
	per_pkg::count_bank_t       counts;
	logic [per_pkg::DATA_W-1:0] core_rdata, ext_rdata;
	per_pkg::ctrl_word_t        ctrl;
	logic                       reset_system;

	// expected register state
	logic [31:0]                exp_comm, exp_phase;
	logic [per_pkg::SEL_W-1:0]  exp_metric;
	logic [per_pkg::SEED_W-1:0] exp_seed;
	logic [31:0]                snap_cache0, snap_cache1;
	logic [31:0]                snap_count [per_pkg::N_COUNTERS];

	logic [31:0]  lfsr = 32'h0ec5_950c;
	logic [31:0]  drawn;
	logic [103:0] stim_mem [STIM_DEPTH]; // op_port_addr_data_expect
	int           checks, errors;
	logic         timed_out;

	peripheral_system dut_i (
		.clock_i        (clock        ),
		.rst_n_i        (rst_n        ),
		.core_req_i     (core_req     ),
		.ext_req_i      (ext_req      ),
		.cache0_i       (cache0       ),
		.cache1_i       (cache1       ),
		.counts_i       (counts       ),
		.core_rdata_o   (core_rdata   ),
		.ext_rdata_o    (ext_rdata    ),
		.ctrl_o         (ctrl         ),
		.reset_system_o (reset_system )
	);

	always #50 clock = ~clock; // 100 ns period

	// ----------------------------------------
	// status stimulus from a galois lfsr
	// ----------------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // x^32+x^22+x^2+x+1
	endfunction

	task automatic draw_word(output logic [31:0] w);
		for (int b = 0; b < 32; b++) begin
			w[b] = lfsr[0];          // one step per bit
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// new live status every falling edge
	always @(negedge clock) begin
		draw_word(cache0);
		draw_word(cache1);
		for (int k = 0; k < per_pkg::N_COUNTERS; k++) begin
			draw_word(drawn);
			counts.word[k] = drawn;
		end
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------
	task automatic check_word(input string what, input logic [31:0] got,
			input logic [31:0] expv);
		checks++;
		assert (got === expv) else begin
			errors++;
			$display("ERR %0t: %s is 0x%h, expected 0x%h", $time, what, got, expv);
		end
	endtask

	task automatic check_ctrl(input string when_s);
		check_word({"ctrl_o comm ", when_s}, ctrl.comm, exp_comm);
		check_word({"ctrl_o phase ", when_s}, ctrl.phase, exp_phase);
		check_word({"ctrl_o metric select ", when_s}, 32'(ctrl.metric_sel), 32'(exp_metric));
		check_word({"ctrl_o seed ", when_s}, 32'(ctrl.seed), 32'(exp_seed));
	endtask

	// ----------------------------------------
	// bus operations
	// ----------------------------------------
	task automatic drive_req(input logic port, input logic rw, input logic [31:0] addr,
			input logic [31:0] data);
		per_pkg::bus_req_t r;
		r.req  = 1'b1;
		r.rw   = rw;
		r.add  = addr[per_pkg::ADDR_W-1:0];
		r.data = data;
		if (port)
			ext_req = r;
		else
			core_req = r;
	endtask

	task automatic step_cycle();
		@(posedge clock);
		@(negedge clock);   // outputs settled here
		core_req = '0;      // strobes last one clock
		ext_req  = '0;
	endtask

	// writable fields truncated to their width
	task automatic apply_write(input logic [31:0] addr, input logic [31:0] data);
		case (addr)
			32'h00:  exp_comm   = data;
			32'h04:  exp_metric = data[per_pkg::SEL_W-1:0];
			32'h08:  exp_seed   = data[per_pkg::SEED_W-1:0];
			32'h0C:  exp_phase  = data;
			default: ;          // read only, command or unmapped
		endcase
	endtask

	task automatic write_reg(input logic port, input logic [31:0] addr,
			input logic [31:0] data);
		check_ctrl("before write");
		drive_req(port, 1'b1, addr, data);
		step_cycle();
		apply_write(addr, data);
		check_ctrl("after write"); // new value from the write edge
	endtask

	task automatic read_and_check(input logic port, input logic [31:0] addr,
			input logic [31:0] expv);
		string what;
		what = $sformatf("%s read of 0x%h", port ? "ext" : "core", addr);
		drive_req(port, 1'b0, addr, 32'h0);
		step_cycle();
		check_word(what, port ? ext_rdata : core_rdata, expv);
		step_cycle();       // data must hold without a read
		check_word({what, " held"}, port ? ext_rdata : core_rdata, expv);
	endtask

	task automatic write_both(input logic [31:0] addr_pair, input logic [31:0] core_data,
			input logic [31:0] ext_data);
		logic [31:0] core_addr, ext_addr;
		core_addr = {16'h0, addr_pair[15:0]};
		ext_addr  = {16'h0, addr_pair[31:16]};
		drive_req(1'b0, 1'b1, core_addr, core_data);
		drive_req(1'b1, 1'b1, ext_addr, ext_data);
		step_cycle();
		apply_write(ext_addr, ext_data);
		apply_write(core_addr, core_data);  // core wins a shared register
		check_ctrl("after dual write");
	endtask

	task automatic capture_and_read(input logic port);
		drive_req(port, 1'b1, 32'h1C, 32'h0);
		@(posedge clock);                   // inputs the dut samples now
		snap_cache0 = cache0;
		snap_cache1 = cache1;
		for (int k = 0; k < per_pkg::N_COUNTERS; k++)
			snap_count[k] = counts.word[k];
		@(negedge clock);
		core_req = '0;
		ext_req  = '0;
		// live inputs keep moving during these reads
		read_and_check(port, 32'h14, snap_cache0);
		read_and_check(port, 32'h18, snap_cache1);
		for (int k = 0; k < per_pkg::N_COUNTERS; k++)
			read_and_check(port, 32'h20 + 32'(4 * k), snap_count[k]);
	endtask

	task automatic pulse_reset(input logic port, input logic [31:0] data,
			input logic [31:0] len);
		int high;
		check_word("reset_system_o before command", {31'b0, reset_system}, 32'h0);
		drive_req(port, 1'b1, 32'h10, data);
		step_cycle();
		high = 0;
		while (reset_system === 1'b1 && high < WAIT_LIMIT) begin
			high++;
			if (high == 2)
				drive_req(port, 1'b0, 32'h10, 32'h0);  // busy read
			if (high == 3)
				check_word("busy during pulse", port ? ext_rdata : core_rdata, 32'h1);
			if (high == 6)
				drive_req(~port, 1'b1, 32'h10, 32'h1); // second command is ignored
			step_cycle();
		end
		if (high >= WAIT_LIMIT) begin
			errors++;
			timed_out = 1'b1;
			$display("timeout at %0t: system reset pulse never ended", $time);
		end else begin
			check_word("system reset pulse length", high, len);
			read_and_check(port, 32'h10, 32'h0);
			check_ctrl("after system reset");    // control words survive it
		end
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		int           n;
		logic         done;
		logic [103:0] rec;
		logic [3:0]   op;
		logic         port;
		logic [31:0]  addr, data, expv;
		checks     = 0;
		errors     = 0;
		timed_out  = 1'b0;
		rst_n      = 1'b0;
		core_req   = '0;
		ext_req    = '0;
		cache0     = '0;
		cache1     = '0;
		counts     = '0;
		exp_comm   = 32'h0;
		exp_phase  = 32'h1;
		exp_metric = '0;
		exp_seed   = '0;
		$readmemh("verification/periph_stim.txt", stim_mem);

		repeat (4) begin   // reset held 4 cycles
			@(negedge clock);
			check_word("reset_system_o in reset", {31'b0, reset_system}, 32'h1);
			check_word("core read data in reset", core_rdata, 32'h0);
			check_word("ext read data in reset", ext_rdata, 32'h0);
			check_ctrl("in reset");
		end
		rst_n = 1'b1;
		@(negedge clock);
		check_word("reset_system_o after release", {31'b0, reset_system}, 32'h0);

		n    = 0;
		done = 1'b0;
		while (!done && !timed_out && n < STIM_DEPTH) begin
			rec  = stim_mem[n];
			op   = rec[103:100];
			port = rec[96];
			addr = rec[95:64];
			data = rec[63:32];
			expv = rec[31:0];
			case (op)
				OP_WRITE: write_reg(port, addr, data);
				OP_READ:  read_and_check(port, addr, expv);
				OP_BOTH:  write_both(addr, data, expv);
				OP_SNAP:  capture_and_read(port);
				OP_RESET: pulse_reset(port, data, expv);
				OP_END:   done = 1'b1;
				default: begin
					errors++;
					$display("stimulus line %0d holds an unknown operation %h", n, op);
					done = 1'b1;
				end
			endcase
			n++;
		end
		if (!done && !timed_out) begin
			errors++;
			$display("stimulus file has no end marker");
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/periph_stim.txt ====
// op_port_addr_data_expect, op 1 write 2 read 3 both-write 4 snap 5 reset f end
// port 0 core 1 ext; both-write addr = {ext, core}, expect = ext data; reset expect = length
2_0_00000000_00000000_00000000 // comm reset value
2_1_0000000c_00000000_00000001 // phase reset value
2_0_00000004_00000000_00000000 // metric
2_1_00000008_00000000_00000000 // seed
2_0_00000010_00000000_00000000 // not busy
1_0_00000000_a5a5c3c3_00000000 // comm
2_1_00000000_00000000_a5a5c3c3
1_1_00000004_ffffffff_00000000 // metric, 2 bits kept
2_0_00000004_00000000_00000003
1_0_00000008_fedcba98_00000000 // seed, 19 bits kept
2_0_00000008_00000000_0004ba98
1_1_0000000c_12345678_00000000 // phase
2_1_0000000c_00000000_12345678
1_0_00000014_deadbeef_00000000 // cache0 read only
2_0_00000014_00000000_00000000
1_1_00000028_deadbeef_00000000 // counter 2 read only
2_1_00000028_00000000_00000000
2_0_00000040_00000000_00000000 // unmapped
2_1_00000006_00000000_00000000 // misaligned
1_0_00000002_11111111_00000000 // misaligned write dropped
2_0_00000000_00000000_a5a5c3c3
3_0_000c0000_0000beef_00000002 // core comm, ext phase
2_0_00000000_00000000_0000beef
2_1_0000000c_00000000_00000002
3_0_00080008_00011111_0007ffff // both on seed, core wins
2_1_00000008_00000000_00011111
4_0_00000000_00000000_00000000 // capture from core
4_1_00000000_00000000_00000000 // capture from ext
5_0_00000010_00000001_00000010 // pulse of 16
5_1_00000010_00000000_00000000 // bit 0 clear, no pulse
5_1_00000010_00000003_00000010
2_0_00000000_00000000_0000beef
f_0_00000000_00000000_00000000

// ==== compile.f ====
hw/per_pkg.sv
hw/per_snapshot.sv
hw/per_reset_gen.sv
hw/per_regs.sv
hw/per_ctrl.sv
hw/peripheral_system.sv
verification/tb_peripheral_system.sv

// ==== Makefile ====
# Verilator build and run for the peripheral system testbench

VERILATOR ?= verilator
TOP       ?= tb_peripheral_system
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= tests failed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# a crash also counts as a failure
run: compile
	@./$(SIM_BIN) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
